//--- design/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 64;
    localparam int LINE_BEATS = 4;  // doublewords per line

    localparam logic [ADDR_WIDTH-1:0] CLINT_MTIME    = 32'h0200_0000;
    localparam logic [ADDR_WIDTH-1:0] CLINT_MTIMECMP = 32'h0200_4000;

    // func3 encoding of loads and stores
    typedef enum logic [2:0] {
        SZ_B  = 3'b000,
        SZ_H  = 3'b001,
        SZ_W  = 3'b010,
        SZ_D  = 3'b011,
        SZ_BU = 3'b100,
        SZ_HU = 3'b101,
        SZ_WU = 3'b110
    } mem_size_e;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic                  wen;
        mem_size_e             size;
    } mem_req_t;

    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] addr;
        logic [7:0]            len;   // beats minus one
    } bus_rd_req_t;

    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [DATA_WIDTH-1:0] data;
    } bus_wr_req_t;

    typedef struct packed {
        logic                  en;
        logic                  rw;    // 1 on write
        logic                  sel;   // 0 mtime, 1 mtimecmp
        logic [DATA_WIDTH-1:0] wdata;
    } timer_req_t;

endpackage

`default_nettype wire

//--- design/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
    input  wire logic                              clk_i,
    input  wire logic                              arst_n_i,
    // pipeline side
    input  wire mem_pkg::mem_req_t                 req_i,
    input  wire logic                              mem_valid_i,
    input  wire logic                              fence_i,
    output logic                                   mem_ready_o,
    output logic [mem_pkg::DATA_WIDTH-1:0]         r_data_o,
    // data cache side
    output logic                                   cache_valid_o,
    input  wire logic                              cache_ready_i,
    input  wire logic [mem_pkg::DATA_WIDTH-1:0]    cache_rdata_i,
    // timer side
    output mem_pkg::timer_req_t                    timer_req_o,
    input  wire logic                              timer_ready_i,
    input  wire logic [mem_pkg::DATA_WIDTH-1:0]    timer_rdata_i
);

    logic                           is_mtime;
    logic                           is_mtimecmp;
    logic                           to_timer;
    logic                           pend_q;
    logic [mem_pkg::DATA_WIDTH-1:0] load_data;

    assign is_mtime    = (req_i.addr == mem_pkg::CLINT_MTIME);
    assign is_mtimecmp = (req_i.addr == mem_pkg::CLINT_MTIMECMP);
    assign to_timer    = (is_mtime || is_mtimecmp) && !fence_i;  // fence always goes to cache

    assign cache_valid_o = mem_valid_i && !to_timer;

    // timer request goes out once, then waits for its ready pulse
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_q <= 1'b0;
        end else if (timer_ready_i) begin
            pend_q <= 1'b0;
        end else if (timer_req_o.en) begin
            pend_q <= 1'b1;
        end
    end

    always_comb begin
        timer_req_o.en    = mem_valid_i && to_timer && !pend_q;
        timer_req_o.rw    = req_i.wen;
        timer_req_o.sel   = is_mtimecmp;
        timer_req_o.wdata = req_i.wdata;
    end

    // cache data arrives with the addressed byte at bit 0
    always_comb begin
        case (req_i.size)
            mem_pkg::SZ_B:  load_data = {{56{cache_rdata_i[7]}}, cache_rdata_i[7:0]};
            mem_pkg::SZ_H:  load_data = {{48{cache_rdata_i[15]}}, cache_rdata_i[15:0]};
            mem_pkg::SZ_W:  load_data = {{32{cache_rdata_i[31]}}, cache_rdata_i[31:0]};
            mem_pkg::SZ_D:  load_data = cache_rdata_i;
            mem_pkg::SZ_BU: load_data = {56'd0, cache_rdata_i[7:0]};
            mem_pkg::SZ_HU: load_data = {48'd0, cache_rdata_i[15:0]};
            mem_pkg::SZ_WU: load_data = {32'd0, cache_rdata_i[31:0]};
            default:        load_data = '0;
        endcase
    end

    assign mem_ready_o = to_timer ? timer_ready_i : cache_ready_i;

    always_comb begin
        if (req_i.wen) begin
            r_data_o = '0;  // stores return nothing
        end else if (to_timer) begin
            r_data_o = timer_rdata_i;
        end else begin
            r_data_o = load_data;
        end
    end

endmodule

`default_nettype wire

//--- design/dcache.sv
`timescale 1ns/10ps
`default_nettype none

module dcache #(
    parameter int LINES = 8
) (
    input  wire logic                              clk_i,
    input  wire logic                              arst_n_i,
    // request side
    input  wire mem_pkg::mem_req_t                 req_i,
    input  wire logic                              valid_i,
    input  wire logic                              fence_i,
    output logic                                   ready_o,
    output logic [mem_pkg::DATA_WIDTH-1:0]         rdata_o,
    output logic [63:0]                            hit_cnt_o,
    output logic [63:0]                            miss_cnt_o,
    // memory read channel
    output mem_pkg::bus_rd_req_t                   rd_req_o,
    input  wire logic                              bus_r_ready_i,
    input  wire logic                              bus_r_last_i,
    input  wire logic [mem_pkg::DATA_WIDTH-1:0]    bus_r_data_i,
    // memory write channel
    output mem_pkg::bus_wr_req_t                   wr_req_o,
    input  wire logic                              bus_w_ready_i,
    input  wire logic                              bus_w_last_i
);

    localparam int         IDX_W     = $clog2(LINES);
    localparam int         BEAT_W    = $clog2(mem_pkg::LINE_BEATS);
    localparam int         OFF_W     = BEAT_W + 3;
    localparam int         TAG_W     = mem_pkg::ADDR_WIDTH - IDX_W - OFF_W;
    localparam logic [7:0] BURST_LEN = 8'(mem_pkg::LINE_BEATS - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_EVICT,
        S_REFILL,
        S_FLUSH
    } state_e;

    state_e                         state_q;
    logic [BEAT_W-1:0]              beat_q;
    logic [IDX_W-1:0]               flush_idx_q;
    logic                           retry_q;   // lookup after refill is already counted
    logic [LINES-1:0]               valid_q;
    logic [LINES-1:0]               dirty_q;
    logic [TAG_W-1:0]               tag_q  [LINES];
    logic [mem_pkg::DATA_WIDTH-1:0] data_q [LINES][mem_pkg::LINE_BEATS];

    logic [TAG_W-1:0]               req_tag;
    logic [IDX_W-1:0]               req_idx;
    logic [IDX_W-1:0]               ev_idx;
    logic [BEAT_W-1:0]              req_beat;
    logic [2:0]                     req_off;
    logic [1:0]                     size_bits;
    logic                           hit;
    logic                           wb_needed;
    logic                           flush_done;
    logic [7:0]                     size_mask;
    logic [7:0]                     be_mask;
    logic [mem_pkg::DATA_WIDTH-1:0] line_word;
    logic [mem_pkg::DATA_WIDTH-1:0] wdata_sh;
    logic [mem_pkg::DATA_WIDTH-1:0] merged;

    assign req_tag   = req_i.addr[mem_pkg::ADDR_WIDTH-1 -: TAG_W];
    assign req_idx   = req_i.addr[OFF_W +: IDX_W];
    assign req_beat  = req_i.addr[3 +: BEAT_W];
    assign req_off   = req_i.addr[2:0];
    assign size_bits = req_i.size[1:0];

    assign hit        = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
    assign ev_idx     = fence_i ? flush_idx_q : req_idx;  // flush walks its own index
    assign wb_needed  = valid_q[flush_idx_q] && dirty_q[flush_idx_q];
    assign flush_done = (state_q == S_FLUSH) && !wb_needed
                        && (flush_idx_q == IDX_W'(LINES - 1));

    assign ready_o   = ((state_q == S_LOOKUP) && hit) || flush_done;
    assign line_word = data_q[req_idx][req_beat];
    assign rdata_o   = line_word >> {req_off, 3'b000};

    // byte lanes of a store
    always_comb begin
        case (size_bits)
            2'd0:    size_mask = 8'h01;
            2'd1:    size_mask = 8'h03;
            2'd2:    size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
        be_mask  = size_mask << req_off;
        wdata_sh = req_i.wdata << {req_off, 3'b000};
    end

    always_comb begin
        merged = line_word;
        for (int b = 0; b < 8; b++) begin
            if (be_mask[b]) begin
                merged[8*b +: 8] = wdata_sh[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= S_IDLE;
            beat_q      <= '0;
            flush_idx_q <= '0;
            retry_q     <= 1'b0;
            valid_q     <= '0;
            dirty_q     <= '0;
            hit_cnt_o   <= '0;
            miss_cnt_o  <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    beat_q <= '0;
                    if (valid_i && fence_i) begin
                        flush_idx_q <= '0;
                        state_q     <= S_FLUSH;
                    end else if (valid_i) begin
                        state_q <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (hit) begin
                        if (!retry_q) hit_cnt_o <= hit_cnt_o + 64'd1;
                        if (req_i.wen) dirty_q[req_idx] <= 1'b1;
                        retry_q <= 1'b0;
                        state_q <= S_IDLE;
                    end else begin
                        miss_cnt_o <= miss_cnt_o + 64'd1;
                        state_q    <= (valid_q[req_idx] && dirty_q[req_idx]) ? S_EVICT : S_REFILL;
                    end
                end
                S_EVICT: begin
                    if (bus_w_ready_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (bus_w_last_i) begin
                            beat_q          <= '0;
                            dirty_q[ev_idx] <= 1'b0;
                            state_q         <= fence_i ? S_FLUSH : S_REFILL;
                        end
                    end
                end
                S_REFILL: begin
                    if (bus_r_ready_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (bus_r_last_i) begin
                            beat_q           <= '0;
                            valid_q[req_idx] <= 1'b1;
                            dirty_q[req_idx] <= 1'b0;
                            retry_q          <= 1'b1;
                            state_q          <= S_LOOKUP;
                        end
                    end
                end
                S_FLUSH: begin
                    if (wb_needed) begin
                        state_q <= S_EVICT;
                    end else if (flush_done) begin
                        valid_q <= '0;
                        dirty_q <= '0;
                        state_q <= S_IDLE;
                    end else begin
                        flush_idx_q <= flush_idx_q + 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // line storage, refill beats and store merges
    always_ff @(posedge clk_i) begin
        if ((state_q == S_REFILL) && bus_r_ready_i) begin
            data_q[req_idx][beat_q] <= bus_r_data_i;
            if (bus_r_last_i) tag_q[req_idx] <= req_tag;
        end else if ((state_q == S_LOOKUP) && hit && req_i.wen) begin
            data_q[req_idx][req_beat] <= merged;
        end
    end

    always_comb begin
        rd_req_o.valid = (state_q == S_REFILL);
        rd_req_o.addr  = {req_tag, req_idx, {OFF_W{1'b0}}};
        rd_req_o.len   = BURST_LEN;

        wr_req_o.valid = (state_q == S_EVICT);
        wr_req_o.addr  = {tag_q[ev_idx], ev_idx, {OFF_W{1'b0}}};
        wr_req_o.len   = BURST_LEN;
        wr_req_o.size  = mem_pkg::SZ_D;
        wr_req_o.data  = data_q[ev_idx][beat_q];  // advances only on accepted beat
    end

endmodule

`default_nettype wire

//--- design/clint_timer.sv
`timescale 1ns/10ps
`default_nettype none

module clint_timer (
    input  wire logic                           clk_i,
    input  wire logic                           arst_n_i,
    input  wire mem_pkg::timer_req_t            req_i,
    output logic                                ready_o,
    output logic [mem_pkg::DATA_WIDTH-1:0]      rdata_o,
    output logic                                mtip_o
);

    logic [mem_pkg::DATA_WIDTH-1:0] mtime_q;
    logic [mem_pkg::DATA_WIDTH-1:0] mtimecmp_q;
    logic                           wr_en;
    logic                           rd_en;

    assign wr_en = req_i.en && req_i.rw;
    assign rd_en = req_i.en && !req_i.rw;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;  // no interrupt until programmed
            ready_o    <= 1'b0;
            mtip_o     <= 1'b0;
        end else begin
            if (wr_en && !req_i.sel) begin
                mtime_q <= req_i.wdata;
            end else begin
                mtime_q <= mtime_q + 64'd1;
            end
            if (wr_en && req_i.sel) begin
                mtimecmp_q <= req_i.wdata;
            end
            ready_o <= req_i.en;  // one cycle after the request
            mtip_o  <= (mtime_q >= mtimecmp_q);
        end
    end

    // read data lines up with ready_o
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_o <= req_i.sel ? mtimecmp_q : mtime_q;
        end
    end

endmodule

`default_nettype wire

//--- design/mem_subsys_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_top #(
    parameter int LINES = 8
) (
    input  wire logic                              clk_i,
    input  wire logic                              arst_n_i,
    // pipeline
    input  wire mem_pkg::mem_req_t                 req_i,
    input  wire logic                              mem_valid_i,
    input  wire logic                              fence_i,
    output logic                                   mem_ready_o,
    output logic [mem_pkg::DATA_WIDTH-1:0]         r_data_o,
    // performance counters
    output logic [63:0]                            hit_cnt_o,
    output logic [63:0]                            miss_cnt_o,
    // memory bus
    output mem_pkg::bus_rd_req_t                   rd_req_o,
    input  wire logic                              bus_r_ready_i,
    input  wire logic                              bus_r_last_i,
    input  wire logic [mem_pkg::DATA_WIDTH-1:0]    bus_r_data_i,
    output mem_pkg::bus_wr_req_t                   wr_req_o,
    input  wire logic                              bus_w_ready_i,
    input  wire logic                              bus_w_last_i,
    // timer interrupt
    output logic                                   mtip_o
);

    logic                           cache_valid;
    logic                           cache_ready;
    logic [mem_pkg::DATA_WIDTH-1:0] cache_rdata;
    mem_pkg::timer_req_t            timer_req;
    logic                           timer_ready;
    logic [mem_pkg::DATA_WIDTH-1:0] timer_rdata;

    mem_stage i_mem_stage (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .req_i         (req_i),
        .mem_valid_i   (mem_valid_i),
        .fence_i       (fence_i),
        .mem_ready_o   (mem_ready_o),
        .r_data_o      (r_data_o),
        .cache_valid_o (cache_valid),
        .cache_ready_i (cache_ready),
        .cache_rdata_i (cache_rdata),
        .timer_req_o   (timer_req),
        .timer_ready_i (timer_ready),
        .timer_rdata_i (timer_rdata)
    );

    dcache #(
        .LINES (LINES)
    ) i_dcache (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .req_i         (req_i),
        .valid_i       (cache_valid),
        .fence_i       (fence_i),
        .ready_o       (cache_ready),
        .rdata_o       (cache_rdata),
        .hit_cnt_o     (hit_cnt_o),
        .miss_cnt_o    (miss_cnt_o),
        .rd_req_o      (rd_req_o),
        .bus_r_ready_i (bus_r_ready_i),
        .bus_r_last_i  (bus_r_last_i),
        .bus_r_data_i  (bus_r_data_i),
        .wr_req_o      (wr_req_o),
        .bus_w_ready_i (bus_w_ready_i),
        .bus_w_last_i  (bus_w_last_i)
    );

    clint_timer i_clint_timer (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (timer_req),
        .ready_o  (timer_ready),
        .rdata_o  (timer_rdata),
        .mtip_o   (mtip_o)
    );

endmodule

`default_nettype wire

//--- test/mem_subsys_checker.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_checker (
    input  wire logic                  clk_i,
    input  wire logic                  arst_n_i,
    input  wire logic                  valid_i,
    input  wire logic                  ready_i,
    input  wire mem_pkg::mem_req_t     req_i,
    input  wire mem_pkg::bus_rd_req_t  rd_req_i,
    input  wire logic                  r_ready_i,
    input  wire logic                  r_last_i,
    input  wire mem_pkg::bus_wr_req_t  wr_req_i,
    input  wire logic                  w_ready_i,
    input  wire logic                  w_last_i
);

    int unsigned fail_cnt = 0;  // read by the testbench monitor

    ready_in_reset_a: assert property (@(posedge clk_i) !arst_n_i |-> !ready_i)
        else begin
            fail_cnt++;
            $error("ready high while reset is asserted");
        end

    // pipeline and cache side hold the request until ready
    req_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_i && !ready_i |=> valid_i && $stable(req_i))
        else begin
            fail_cnt++;
            $error("request changed or dropped before ready");
        end

    rd_burst_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rd_req_i.valid && !(r_ready_i && r_last_i) |=> rd_req_i.valid
            && $stable(rd_req_i.addr))
        else begin
            fail_cnt++;
            $error("read burst valid or address changed before last beat");
        end

    wr_burst_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wr_req_i.valid && !(w_ready_i && w_last_i) |=> wr_req_i.valid
            && $stable(wr_req_i.addr))
        else begin
            fail_cnt++;
            $error("write burst valid or address changed before last beat");
        end

endmodule

// pipeline handshake only, bus ports tied off
bind mem_stage mem_subsys_checker i_stage_chk (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .valid_i   (mem_valid_i),
    .ready_i   (mem_ready_o),
    .req_i     (req_i),
    .rd_req_i  ('0),
    .r_ready_i (1'b0),
    .r_last_i  (1'b0),
    .wr_req_i  ('0),
    .w_ready_i (1'b0),
    .w_last_i  (1'b0)
);

bind dcache mem_subsys_checker i_cache_chk (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .valid_i   (valid_i),
    .ready_i   (ready_o),
    .req_i     (req_i),
    .rd_req_i  (rd_req_o),
    .r_ready_i (bus_r_ready_i),
    .r_last_i  (bus_r_last_i),
    .wr_req_i  (wr_req_o),
    .w_ready_i (bus_w_ready_i),
    .w_last_i  (bus_w_last_i)
);

`default_nettype wire

//--- test/mem_subsys_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_tb;

    localparam int LINES       = 8;
    localparam int LINE_BYTES  = 32;
    localparam int MEM_BYTES   = 1024;  // all test addresses live below this
    localparam int N_STEPS     = 36;
    localparam int CYCLE_LIMIT = N_STEPS * 200 + 1000;

    typedef enum logic [1:0] {OP_LD, OP_ST, OP_FENCE, OP_NOP} op_e;
    typedef enum logic [1:0] {CK_NONE, CK_DATA, CK_LINE, CK_ALL} chk_e;

    typedef struct packed {
        op_e                op;
        logic [31:0]        addr;
        mem_pkg::mem_size_e size;
        logic [63:0]        wdata;
        chk_e               chk;
    } step_t;

    localparam step_t STEPS [N_STEPS] = '{
        // one doubleword read back with every load size
        '{OP_ST,    32'h040, mem_pkg::SZ_D,  64'h8877_f655_4433_a211, CK_NONE},
        '{OP_LD,    32'h040, mem_pkg::SZ_B,  64'h0, CK_DATA},
        '{OP_LD,    32'h041, mem_pkg::SZ_B,  64'h0, CK_DATA},
        '{OP_LD,    32'h047, mem_pkg::SZ_B,  64'h0, CK_DATA},
        '{OP_LD,    32'h041, mem_pkg::SZ_BU, 64'h0, CK_DATA},
        '{OP_LD,    32'h047, mem_pkg::SZ_BU, 64'h0, CK_DATA},
        '{OP_LD,    32'h042, mem_pkg::SZ_H,  64'h0, CK_DATA},
        '{OP_LD,    32'h046, mem_pkg::SZ_H,  64'h0, CK_DATA},
        '{OP_LD,    32'h046, mem_pkg::SZ_HU, 64'h0, CK_DATA},
        '{OP_LD,    32'h040, mem_pkg::SZ_W,  64'h0, CK_DATA},
        '{OP_LD,    32'h044, mem_pkg::SZ_W,  64'h0, CK_DATA},
        '{OP_LD,    32'h044, mem_pkg::SZ_WU, 64'h0, CK_DATA},
        '{OP_LD,    32'h040, mem_pkg::SZ_D,  64'h0, CK_DATA},
        // narrow stores merged into one doubleword
        '{OP_ST,    32'h048, mem_pkg::SZ_B,  64'h0000_0000_0000_00ee, CK_NONE},
        '{OP_ST,    32'h04a, mem_pkg::SZ_H,  64'h0000_0000_0000_9abc, CK_NONE},
        '{OP_ST,    32'h04c, mem_pkg::SZ_W,  64'h0000_0000_dead_beef, CK_NONE},
        '{OP_LD,    32'h048, mem_pkg::SZ_D,  64'h0, CK_DATA},
        // fresh lines followed by repeats
        '{OP_LD,    32'h060, mem_pkg::SZ_D,  64'h0, CK_DATA},
        '{OP_LD,    32'h068, mem_pkg::SZ_W,  64'h0, CK_DATA},
        '{OP_LD,    32'h080, mem_pkg::SZ_HU, 64'h0, CK_DATA},
        '{OP_LD,    32'h07c, mem_pkg::SZ_WU, 64'h0, CK_DATA},
        // dirty line pushed out by an alias of the same index
        '{OP_ST,    32'h0a8, mem_pkg::SZ_D,  64'h0123_4567_89ab_cdef, CK_NONE},
        '{OP_LD,    32'h1a0, mem_pkg::SZ_D,  64'h0, CK_DATA},
        '{OP_NOP,   32'h0a0, mem_pkg::SZ_D,  64'h0, CK_LINE},
        '{OP_ST,    32'h1b3, mem_pkg::SZ_B,  64'h0000_0000_0000_005a, CK_NONE},
        '{OP_LD,    32'h0a8, mem_pkg::SZ_D,  64'h0, CK_DATA},
        '{OP_NOP,   32'h1a0, mem_pkg::SZ_D,  64'h0, CK_LINE},
        // several dirty lines written back by a fence
        '{OP_ST,    32'h000, mem_pkg::SZ_D,  64'hfedc_ba98_7654_3210, CK_NONE},
        '{OP_ST,    32'h024, mem_pkg::SZ_W,  64'h0000_0000_8000_0001, CK_NONE},
        '{OP_ST,    32'h0c5, mem_pkg::SZ_B,  64'h0000_0000_0000_0081, CK_NONE},
        '{OP_ST,    32'h0e6, mem_pkg::SZ_H,  64'h0000_0000_0000_c3c3, CK_NONE},
        '{OP_FENCE, 32'h000, mem_pkg::SZ_D,  64'h0, CK_ALL},
        '{OP_LD,    32'h000, mem_pkg::SZ_D,  64'h0, CK_DATA},
        '{OP_LD,    32'h024, mem_pkg::SZ_W,  64'h0, CK_DATA},
        '{OP_LD,    32'h0c5, mem_pkg::SZ_B,  64'h0, CK_DATA},
        '{OP_LD,    32'h0e6, mem_pkg::SZ_HU, 64'h0, CK_DATA}
    };

    logic                 clk_i;
    logic                 arst_n_i;
    mem_pkg::mem_req_t    req_i;
    logic                 mem_valid_i;
    logic                 fence_i;
    logic                 mem_ready_o;
    logic [63:0]          r_data_o;
    logic [63:0]          hit_cnt_o;
    logic [63:0]          miss_cnt_o;
    mem_pkg::bus_rd_req_t rd_req_o;
    logic                 bus_r_ready_i;
    logic                 bus_r_last_i;
    logic [63:0]          bus_r_data_i;
    mem_pkg::bus_wr_req_t wr_req_o;
    logic                 bus_w_ready_i;
    logic                 bus_w_last_i;
    logic                 mtip_o;

    logic [7:0]  shadow  [MEM_BYTES];  // what the memory should hold
    logic [7:0]  backing [MEM_BYTES];  // what the bus actually wrote
    logic        line_valid [LINES];
    int unsigned line_tag   [LINES];
    logic [63:0] exp_hits;
    logic [63:0] exp_misses;
    int          cycles = 0;

    mem_subsys_top #(
        .LINES (LINES)
    ) i_dut (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .req_i         (req_i),
        .mem_valid_i   (mem_valid_i),
        .fence_i       (fence_i),
        .mem_ready_o   (mem_ready_o),
        .r_data_o      (r_data_o),
        .hit_cnt_o     (hit_cnt_o),
        .miss_cnt_o    (miss_cnt_o),
        .rd_req_o      (rd_req_o),
        .bus_r_ready_i (bus_r_ready_i),
        .bus_r_last_i  (bus_r_last_i),
        .bus_r_data_i  (bus_r_data_i),
        .wr_req_o      (wr_req_o),
        .bus_w_ready_i (bus_w_ready_i),
        .bus_w_last_i  (bus_w_last_i),
        .mtip_o        (mtip_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            fail_stop($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    always @(negedge clk_i) begin
        if (i_dut.i_mem_stage.i_stage_chk.fail_cnt != 0
                || i_dut.i_dcache.i_cache_chk.fail_cnt != 0) begin
            fail_stop("a bus or handshake assertion failed");
        end
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            fail_stop("value mismatch");
        end
    endtask

    // background pattern mixing every address bit
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3c;
    endfunction

    function automatic int size_bytes(input mem_pkg::mem_size_e sz);
        return 1 << sz[1:0];  // func3 low bits give log2 width
    endfunction

    function automatic logic [63:0] expect_load(input logic [31:0] a,
                                                input mem_pkg::mem_size_e sz);
        logic [63:0] val;
        int          n;
        n   = size_bytes(sz);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val[8*i +: 8] = shadow[a[9:0] + i];
        end
        if (!sz[2] && n < 8 && val[8*n-1]) begin  // func3[2] clear means signed
            for (int i = 8*n; i < 64; i++) begin
                val[i] = 1'b1;
            end
        end
        return val;
    endfunction

    task automatic store_shadow(input logic [31:0] a, input mem_pkg::mem_size_e sz,
                                input logic [63:0] wd);
        for (int i = 0; i < size_bytes(sz); i++) begin
            shadow[a[9:0] + i] = wd[8*i +: 8];
        end
    endtask

    // expected counters from index and tag of a direct-mapped cache
    task automatic tally(input logic [31:0] a);
        int unsigned idx;
        int unsigned tag;
        idx = (a / LINE_BYTES) % LINES;
        tag = a / (LINE_BYTES * LINES);
        if (line_valid[idx] && line_tag[idx] == tag) begin
            exp_hits = exp_hits + 1;
        end else begin
            exp_misses      = exp_misses + 1;
            line_valid[idx] = 1'b1;
            line_tag[idx]   = tag;
        end
    endtask

    task automatic compare_memory(input int base, input int len);
        for (int i = base; i < base + len; i++) begin
            check($sformatf("backing[%03h]", i), backing[i], shadow[i]);
        end
    endtask

    task automatic access(input logic wen, input logic fen, input logic [31:0] a,
                          input mem_pkg::mem_size_e sz, input logic [63:0] wd,
                          output logic [63:0] rd);
        @(negedge clk_i);
        req_i.addr  = a;
        req_i.wdata = wd;
        req_i.wen   = wen;
        req_i.size  = sz;
        fence_i     = fen;
        mem_valid_i = 1'b1;
        do @(negedge clk_i); while (!mem_ready_o);  // completes on the next rising edge
        rd = r_data_o;
        @(negedge clk_i);
        mem_valid_i = 1'b0;
        fence_i     = 1'b0;
    endtask

    // backing memory with a random gap before every beat
    initial begin : backing_memory
        logic [9:0]  base;
        logic [63:0] beat_data;
        void'($urandom(32'h1d600132));
        bus_r_ready_i = 1'b0;
        bus_r_last_i  = 1'b0;
        bus_r_data_i  = '0;
        bus_w_ready_i = 1'b0;
        bus_w_last_i  = 1'b0;
        forever begin
            @(negedge clk_i);
            if (rd_req_o.valid) begin
                base = rd_req_o.addr[9:0];
                check("rd_req_o.len", rd_req_o.len, 8'd3);  // four beats per burst
                for (int beat = 0; beat < 4; beat++) begin
                    repeat (int'($urandom_range(7, 0))) @(negedge clk_i);
                    for (int b = 0; b < 8; b++) begin
                        beat_data[8*b +: 8] = backing[base + 8*beat + b];
                    end
                    bus_r_data_i  = beat_data;
                    bus_r_ready_i = 1'b1;
                    bus_r_last_i  = (beat == 3);
                    @(negedge clk_i);
                    bus_r_ready_i = 1'b0;
                    bus_r_last_i  = 1'b0;
                end
            end else if (wr_req_o.valid) begin
                base = wr_req_o.addr[9:0];
                check("wr_req_o.len", wr_req_o.len, 8'd3);
                check("wr_req_o.size", wr_req_o.size, 3'd3);  // doubleword beats
                for (int beat = 0; beat < 4; beat++) begin
                    repeat (int'($urandom_range(7, 0))) @(negedge clk_i);
                    for (int b = 0; b < 8; b++) begin
                        backing[base + 8*beat + b] = wr_req_o.data[8*b +: 8];
                    end
                    bus_w_ready_i = 1'b1;
                    bus_w_last_i  = (beat == 3);
                    @(negedge clk_i);
                    bus_w_ready_i = 1'b0;
                    bus_w_last_i  = 1'b0;
                end
            end
        end
    end

    initial begin : stimulus
        step_t       st;
        logic [63:0] rd;
        logic [63:0] t1;
        logic [63:0] t2;
        req_i       = '0;
        mem_valid_i = 1'b0;
        fence_i     = 1'b0;
        arst_n_i    = 1'b0;
        exp_hits    = '0;
        exp_misses  = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            shadow[i]  = fill_byte(i);
            backing[i] = fill_byte(i);
        end
        for (int i = 0; i < LINES; i++) begin
            line_valid[i] = 1'b0;
            line_tag[i]   = 0;
        end
        repeat (16) @(negedge clk_i);
        arst_n_i = 1'b1;

        for (int s = 0; s < N_STEPS; s++) begin
            st = STEPS[s];
            case (st.op)
                OP_LD: begin
                    access(1'b0, 1'b0, st.addr, st.size, '0, rd);
                    tally(st.addr);
                end
                OP_ST: begin
                    access(1'b1, 1'b0, st.addr, st.size, st.wdata, rd);
                    check("r_data_o", rd, 64'd0);  // stores return no data
                    tally(st.addr);
                    store_shadow(st.addr, st.size, st.wdata);
                end
                OP_FENCE: begin
                    access(1'b0, 1'b1, st.addr, st.size, '0, rd);
                    for (int i = 0; i < LINES; i++) begin
                        line_valid[i] = 1'b0;  // every line refetched afterwards
                    end
                end
                default: ;
            endcase
            check("hit_cnt_o", hit_cnt_o, exp_hits);
            check("miss_cnt_o", miss_cnt_o, exp_misses);
            case (st.chk)
                CK_DATA: check("r_data_o", rd, expect_load(st.addr, st.size));
                CK_LINE: compare_memory((st.addr / LINE_BYTES) * LINE_BYTES, LINE_BYTES);
                CK_ALL:  compare_memory(0, MEM_BYTES);
                default: ;
            endcase
        end

        // CLINT timer
        access(1'b1, 1'b0, mem_pkg::CLINT_MTIMECMP, mem_pkg::SZ_D, 64'h0000_1234_5678_9abc, rd);
        access(1'b0, 1'b0, mem_pkg::CLINT_MTIMECMP, mem_pkg::SZ_D, '0, rd);
        check("mtimecmp", rd, 64'h0000_1234_5678_9abc);
        check("mtip_o", mtip_o, 1'b0);
        access(1'b0, 1'b0, mem_pkg::CLINT_MTIME, mem_pkg::SZ_D, '0, t1);
        access(1'b0, 1'b0, mem_pkg::CLINT_MTIME, mem_pkg::SZ_D, '0, t2);
        check("mtime increasing", t2 > t1, 1'b1);
        access(1'b1, 1'b0, mem_pkg::CLINT_MTIMECMP, mem_pkg::SZ_D, t2, rd);
        repeat (2) @(negedge clk_i);  // mtip is one register behind
        check("mtip_o", mtip_o, 1'b1);
        access(1'b1, 1'b0, mem_pkg::CLINT_MTIMECMP, mem_pkg::SZ_D, '1, rd);
        repeat (2) @(negedge clk_i);
        check("mtip_o", mtip_o, 1'b0);

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_subsys_top.f
design/mem_pkg.sv
design/mem_stage.sv
design/dcache.sv
design/clint_timer.sv
design/mem_subsys_top.sv
test/mem_subsys_checker.sv
test/mem_subsys_tb.sv

//--- Bender.yml
package:
  name: mem_subsys

sources:
  - design/mem_pkg.sv
  - design/mem_stage.sv
  - design/dcache.sv
  - design/clint_timer.sv
  - design/mem_subsys_top.sv
  - target: test
    files:
      - test/mem_subsys_checker.sv
      - test/mem_subsys_tb.sv
